// ==== source/cornet_consts.svh ====
`ifndef CORNET_CONSTS_SVH
`define CORNET_CONSTS_SVH

`define CORNET_ADDR_W 16
`define CORNET_DATA_W 8

`define CORNET_RESET_VECTOR 16'hFFFC // Low byte, high byte follows.

// 6502 opcode bytes for the supported instructions.
`define CORNET_OP_LDA_IMM   8'hA9
`define CORNET_OP_LDX_IMM   8'hA2
`define CORNET_OP_LDY_IMM   8'hA0
`define CORNET_OP_LDA_ABS   8'hAD
`define CORNET_OP_LDA_ABS_X 8'hBD
`define CORNET_OP_STA_ABS   8'h8D
`define CORNET_OP_STA_ABS_X 8'h9D
`define CORNET_OP_INX       8'hE8
`define CORNET_OP_DEX       8'hCA
`define CORNET_OP_TAX       8'hAA
`define CORNET_OP_TXA       8'h8A
`define CORNET_OP_AND_IMM   8'h29
`define CORNET_OP_ORA_IMM   8'h09
`define CORNET_OP_ADC_IMM   8'h69
`define CORNET_OP_CMP_IMM   8'hC9
`define CORNET_OP_CLC       8'h18
`define CORNET_OP_SEC       8'h38
`define CORNET_OP_JMP_ABS   8'h4C
`define CORNET_OP_BEQ       8'hF0
`define CORNET_OP_BNE       8'hD0

`endif

// ==== source/cornet_pkg.sv ====
`default_nettype none

`include "cornet_consts.svh"

package cornet_pkg;

   typedef logic [`CORNET_ADDR_W-1:0] addr_t;
   typedef logic [`CORNET_DATA_W-1:0] byte_t;

   typedef enum logic [2:0] {
      FS_WAIT,
      FS_RESET,
      FS_FETCH,
      FS_LOAD_INST,
      FS_EXECUTE,
      FS_EXECUTE_WAIT
   } fetch_state_t;

   // NOP first so that an all-zero decode word is idle.
   typedef enum logic [4:0] {
      OP_NOP,
      OP_RESET,
      OP_LDA,
      OP_LDX,
      OP_LDY,
      OP_LDA_ABS,
      OP_LDA_ABS_X,
      OP_STA_ABS,
      OP_STA_ABS_X,
      OP_INX,
      OP_DEX,
      OP_TAX,
      OP_TXA,
      OP_AND,
      OP_ORA,
      OP_ADC,
      OP_CMP,
      OP_CLC,
      OP_SEC,
      OP_JMP,
      OP_BEQ,
      OP_BNE
   } operation_t;

   typedef enum logic [1:0] {OPND_NONE, OPND_BYTE, OPND_WORD} operand_kind_t;

   typedef enum logic [1:0] {BUS_READ_BYTE, BUS_READ_WORD, BUS_WRITE} bus_kind_t;

   typedef enum logic [2:0] {BS_IDLE, BS_BYTE, BS_WORD_L, BS_WORD_H, BS_WRITE} bus_state_t;

   typedef enum logic [1:0] {EX_IDLE, EX_OPERAND, EX_DATA} exec_state_t;

   typedef struct packed {
      logic      valid;
      bus_kind_t kind;
      addr_t     addr;
      byte_t     wr_data;
   } bus_req_t;

   typedef struct packed {
      operation_t    operation;
      operand_kind_t operand;
      logic [1:0]    len; // Zero when no instruction is issued.
   } decoded_t;

endpackage

`default_nettype wire

// ==== source/cornet_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module cornet_fetch (
   input  wire logic              clk,
   input  wire logic              reset_n,
   output logic                   fetch_req,
   output cornet_pkg::addr_t      fetch_addr,
   input  wire logic              inst_valid,
   input  wire cornet_pkg::byte_t rd_byte,
   output logic                   start,
   output cornet_pkg::byte_t      opcode,
   output cornet_pkg::addr_t      pc,
   output logic                   boot,
   input  wire logic              inst_done,
   input  wire cornet_pkg::addr_t pc_next
);

   cornet_pkg::fetch_state_t state;

   always_ff @(posedge clk)
   begin
      fetch_req <= 1'b0;
      start     <= 1'b0;
      boot      <= 1'b0;
      if (!reset_n)
      begin
         state <= cornet_pkg::FS_WAIT;
      end
      else
      begin
         case (state)
            cornet_pkg::FS_WAIT:
            begin
               boot  <= 1'b1; // Reset runs as a pseudo instruction.
               state <= cornet_pkg::FS_RESET;
            end
            cornet_pkg::FS_RESET:
               state <= cornet_pkg::FS_EXECUTE_WAIT;
            cornet_pkg::FS_FETCH:
            begin
               fetch_req  <= 1'b1;
               fetch_addr <= pc;
               state      <= cornet_pkg::FS_LOAD_INST;
            end
            cornet_pkg::FS_LOAD_INST:
               if (inst_valid)
               begin
                  opcode <= rd_byte;
                  start  <= 1'b1;
                  state  <= cornet_pkg::FS_EXECUTE;
               end
            cornet_pkg::FS_EXECUTE:
               state <= cornet_pkg::FS_EXECUTE_WAIT;
            cornet_pkg::FS_EXECUTE_WAIT:
               if (inst_done)
               begin
                  pc    <= pc_next;
                  state <= cornet_pkg::FS_FETCH;
               end
            default:
               state <= cornet_pkg::FS_WAIT;
         endcase
      end
   end

   a_no_start_in_wait: assert property (@(posedge clk) disable iff (!reset_n)
      (state == cornet_pkg::FS_EXECUTE_WAIT) |-> !start);

   // Execute must finish only an instruction that fetch handed over.
   a_done_when_waiting: assert property (@(posedge clk) disable iff (!reset_n)
      inst_done |-> (state == cornet_pkg::FS_EXECUTE_WAIT));

endmodule

`default_nettype wire

// ==== source/cornet_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cornet_consts.svh"

module cornet_decode (
   input  wire logic              clk,
   input  wire logic              reset_n,
   input  wire logic              start,
   input  wire logic              boot,
   input  wire cornet_pkg::byte_t opcode,
   input  wire cornet_pkg::addr_t pc,
   output cornet_pkg::decoded_t   decoded,
   output cornet_pkg::bus_req_t   operand_req
);

   cornet_pkg::decoded_t dec_next;
   cornet_pkg::addr_t    req_addr;

   function automatic cornet_pkg::decoded_t decode_op(input cornet_pkg::byte_t op);
      cornet_pkg::decoded_t d;
      case (op)
         `CORNET_OP_LDA_IMM:   d = '{cornet_pkg::OP_LDA, cornet_pkg::OPND_BYTE, 2'd2};
         `CORNET_OP_LDX_IMM:   d = '{cornet_pkg::OP_LDX, cornet_pkg::OPND_BYTE, 2'd2};
         `CORNET_OP_LDY_IMM:   d = '{cornet_pkg::OP_LDY, cornet_pkg::OPND_BYTE, 2'd2};
         `CORNET_OP_LDA_ABS:   d = '{cornet_pkg::OP_LDA_ABS, cornet_pkg::OPND_WORD, 2'd3};
         `CORNET_OP_LDA_ABS_X: d = '{cornet_pkg::OP_LDA_ABS_X, cornet_pkg::OPND_WORD, 2'd3};
         `CORNET_OP_STA_ABS:   d = '{cornet_pkg::OP_STA_ABS, cornet_pkg::OPND_WORD, 2'd3};
         `CORNET_OP_STA_ABS_X: d = '{cornet_pkg::OP_STA_ABS_X, cornet_pkg::OPND_WORD, 2'd3};
         `CORNET_OP_INX:       d = '{cornet_pkg::OP_INX, cornet_pkg::OPND_NONE, 2'd1};
         `CORNET_OP_DEX:       d = '{cornet_pkg::OP_DEX, cornet_pkg::OPND_NONE, 2'd1};
         `CORNET_OP_TAX:       d = '{cornet_pkg::OP_TAX, cornet_pkg::OPND_NONE, 2'd1};
         `CORNET_OP_TXA:       d = '{cornet_pkg::OP_TXA, cornet_pkg::OPND_NONE, 2'd1};
         `CORNET_OP_AND_IMM:   d = '{cornet_pkg::OP_AND, cornet_pkg::OPND_BYTE, 2'd2};
         `CORNET_OP_ORA_IMM:   d = '{cornet_pkg::OP_ORA, cornet_pkg::OPND_BYTE, 2'd2};
         `CORNET_OP_ADC_IMM:   d = '{cornet_pkg::OP_ADC, cornet_pkg::OPND_BYTE, 2'd2};
         `CORNET_OP_CMP_IMM:   d = '{cornet_pkg::OP_CMP, cornet_pkg::OPND_BYTE, 2'd2};
         `CORNET_OP_CLC:       d = '{cornet_pkg::OP_CLC, cornet_pkg::OPND_NONE, 2'd1};
         `CORNET_OP_SEC:       d = '{cornet_pkg::OP_SEC, cornet_pkg::OPND_NONE, 2'd1};
         `CORNET_OP_JMP_ABS:   d = '{cornet_pkg::OP_JMP, cornet_pkg::OPND_WORD, 2'd3};
         `CORNET_OP_BEQ:       d = '{cornet_pkg::OP_BEQ, cornet_pkg::OPND_BYTE, 2'd2};
         `CORNET_OP_BNE:       d = '{cornet_pkg::OP_BNE, cornet_pkg::OPND_BYTE, 2'd2};
         default:              d = '{cornet_pkg::OP_NOP, cornet_pkg::OPND_NONE, 2'd1};
      endcase
      return d;
   endfunction

   always_comb
   begin
      dec_next = decode_op(opcode);
      req_addr = pc + cornet_pkg::addr_t'(1);
      if (boot)
      begin
         // Reset acts as a jump through the vector word.
         dec_next = '{cornet_pkg::OP_RESET, cornet_pkg::OPND_WORD, 2'd3};
         req_addr = `CORNET_RESET_VECTOR;
      end
   end

   always_ff @(posedge clk)
   begin
      decoded           <= '0;
      operand_req.valid <= 1'b0;
      if (!reset_n)
      begin
         operand_req <= '0;
      end
      else if (start || boot)
      begin
         decoded             <= dec_next;
         operand_req.valid   <= (dec_next.operand != cornet_pkg::OPND_NONE);
         operand_req.kind    <= (dec_next.operand == cornet_pkg::OPND_WORD) ?
                                cornet_pkg::BUS_READ_WORD : cornet_pkg::BUS_READ_BYTE;
         operand_req.addr    <= req_addr;
         operand_req.wr_data <= '0;
      end
   end

   // Operand bytes requested must match the instruction length.
   a_no_empty_operand: assert property (@(posedge clk) disable iff (!reset_n)
      operand_req.valid |->
         (decoded.len == ((operand_req.kind == cornet_pkg::BUS_READ_WORD) ? 2'd3 : 2'd2)));

endmodule

`default_nettype wire

// ==== source/cornet_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cornet_consts.svh"

module cornet_execute (
   input  wire logic                 clk,
   input  wire logic                 reset_n,
   input  wire cornet_pkg::decoded_t decoded,
   input  wire cornet_pkg::addr_t    pc,
   input  wire logic                 bus_done,
   input  wire cornet_pkg::byte_t    rd_byte,
   input  wire cornet_pkg::addr_t    rd_word,
   output cornet_pkg::bus_req_t      data_req,
   output logic                      inst_done,
   output cornet_pkg::addr_t         pc_next
);

   cornet_pkg::exec_state_t state;
   cornet_pkg::operation_t  op_q;
   logic [1:0]              len_q;
   cornet_pkg::byte_t       reg_a;
   cornet_pkg::byte_t       reg_x;
   cornet_pkg::byte_t       reg_y;
   logic                    flag_z;
   logic                    flag_c;
   logic [`CORNET_DATA_W:0] adc_sum;
   logic                    taken;
   cornet_pkg::addr_t       seq_pc;
   cornet_pkg::addr_t       branch_pc;
   cornet_pkg::addr_t       ea;

   always_comb
   begin
      adc_sum   = {1'b0, reg_a} + {1'b0, rd_byte} + {{`CORNET_DATA_W{1'b0}}, flag_c};
      taken     = (op_q == cornet_pkg::OP_BEQ) ? flag_z : !flag_z;
      seq_pc    = pc + cornet_pkg::addr_t'(len_q);
      branch_pc = pc + cornet_pkg::addr_t'(2) +
                  {{(`CORNET_ADDR_W-`CORNET_DATA_W){rd_byte[7]}}, rd_byte};
      ea        = rd_word;
      if (op_q == cornet_pkg::OP_LDA_ABS_X || op_q == cornet_pkg::OP_STA_ABS_X)
         ea = rd_word + cornet_pkg::addr_t'(reg_x); // Indexed by X.
   end

   always_ff @(posedge clk)
   begin
      inst_done      <= 1'b0;
      data_req.valid <= 1'b0;
      if (!reset_n)
      begin
         state <= cornet_pkg::EX_IDLE;
      end
      else
      begin
         case (state)
            cornet_pkg::EX_IDLE:
               if (decoded.len != 2'd0)
               begin
                  op_q  <= decoded.operation;
                  len_q <= decoded.len;
                  if (decoded.operand == cornet_pkg::OPND_NONE)
                  begin
                     inst_done <= 1'b1; // Register only, done now.
                     pc_next   <= pc + cornet_pkg::addr_t'(decoded.len);
                     case (decoded.operation)
                        cornet_pkg::OP_INX:
                        begin
                           reg_x  <= reg_x + 1'b1;
                           flag_z <= (reg_x == 8'hff);
                        end
                        cornet_pkg::OP_DEX:
                        begin
                           reg_x  <= reg_x - 1'b1;
                           flag_z <= (reg_x == 8'h01);
                        end
                        cornet_pkg::OP_TAX:
                        begin
                           reg_x  <= reg_a;
                           flag_z <= (reg_a == 8'h00);
                        end
                        cornet_pkg::OP_TXA:
                        begin
                           reg_a  <= reg_x;
                           flag_z <= (reg_x == 8'h00);
                        end
                        cornet_pkg::OP_CLC: flag_c <= 1'b0;
                        cornet_pkg::OP_SEC: flag_c <= 1'b1;
                        default: ;
                     endcase
                  end
                  else
                  begin
                     state <= cornet_pkg::EX_OPERAND;
                  end
               end
            cornet_pkg::EX_OPERAND:
               if (bus_done)
               begin
                  inst_done <= 1'b1;
                  pc_next   <= seq_pc;
                  state     <= cornet_pkg::EX_IDLE;
                  case (op_q)
                     cornet_pkg::OP_RESET:
                     begin
                        reg_a   <= '0;
                        reg_x   <= '0;
                        reg_y   <= '0;
                        flag_z  <= 1'b0;
                        flag_c  <= 1'b0;
                        pc_next <= rd_word;
                     end
                     cornet_pkg::OP_LDA:
                     begin
                        reg_a  <= rd_byte;
                        flag_z <= (rd_byte == 8'h00);
                     end
                     cornet_pkg::OP_LDX:
                     begin
                        reg_x  <= rd_byte;
                        flag_z <= (rd_byte == 8'h00);
                     end
                     cornet_pkg::OP_LDY:
                     begin
                        reg_y  <= rd_byte;
                        flag_z <= (rd_byte == 8'h00);
                     end
                     cornet_pkg::OP_AND:
                     begin
                        reg_a  <= reg_a & rd_byte;
                        flag_z <= ((reg_a & rd_byte) == 8'h00);
                     end
                     cornet_pkg::OP_ORA:
                     begin
                        reg_a  <= reg_a | rd_byte;
                        flag_z <= ((reg_a | rd_byte) == 8'h00);
                     end
                     cornet_pkg::OP_ADC:
                     begin
                        {flag_c, reg_a} <= adc_sum;
                        flag_z          <= (adc_sum[7:0] == 8'h00);
                     end
                     cornet_pkg::OP_CMP:
                     begin
                        flag_z <= (reg_a == rd_byte);
                        flag_c <= (reg_a >= rd_byte); // No borrow.
                     end
                     cornet_pkg::OP_JMP: pc_next <= rd_word;
                     cornet_pkg::OP_BEQ, cornet_pkg::OP_BNE:
                        if (taken)
                           pc_next <= branch_pc;
                     cornet_pkg::OP_LDA_ABS, cornet_pkg::OP_LDA_ABS_X:
                     begin
                        inst_done <= 1'b0;
                        data_req  <= '{1'b1, cornet_pkg::BUS_READ_BYTE, ea, 8'h00};
                        state     <= cornet_pkg::EX_DATA;
                     end
                     cornet_pkg::OP_STA_ABS, cornet_pkg::OP_STA_ABS_X:
                     begin
                        inst_done <= 1'b0;
                        data_req  <= '{1'b1, cornet_pkg::BUS_WRITE, ea, reg_a};
                        state     <= cornet_pkg::EX_DATA;
                     end
                     default: ;
                  endcase
               end
            cornet_pkg::EX_DATA:
               if (bus_done)
               begin
                  if (op_q == cornet_pkg::OP_LDA_ABS || op_q == cornet_pkg::OP_LDA_ABS_X)
                  begin
                     reg_a  <= rd_byte;
                     flag_z <= (rd_byte == 8'h00);
                  end
                  inst_done <= 1'b1;
                  pc_next   <= seq_pc;
                  state     <= cornet_pkg::EX_IDLE;
               end
            default:
               state <= cornet_pkg::EX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== source/cornet_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

module cornet_bus (
   input  wire logic                 clk,
   input  wire logic                 reset_n,
   input  wire logic                 fetch_req,
   input  wire cornet_pkg::addr_t    fetch_addr,
   input  wire cornet_pkg::bus_req_t operand_req,
   input  wire cornet_pkg::bus_req_t data_req,
   output logic                      inst_valid,
   output logic                      bus_done,
   output cornet_pkg::byte_t         rd_byte,
   output cornet_pkg::addr_t         rd_word,
   output cornet_pkg::addr_t         addr,
   output logic                      rd_req,
   output logic                      wr_en,
   output cornet_pkg::byte_t         wr_data,
   input  wire cornet_pkg::byte_t    rd_data,
   input  wire logic                 ready
);

   cornet_pkg::bus_state_t state;
   cornet_pkg::bus_req_t   sel_req;
   logic                   is_fetch;

   // Decode and execute never request together.
   assign sel_req = operand_req.valid ? operand_req : data_req;

   always_ff @(posedge clk)
   begin
      rd_req     <= 1'b0;
      wr_en      <= 1'b0;
      inst_valid <= 1'b0;
      bus_done   <= 1'b0;
      if (!reset_n)
      begin
         state <= cornet_pkg::BS_IDLE;
      end
      else
      begin
         case (state)
            cornet_pkg::BS_IDLE:
               if (fetch_req)
               begin
                  addr     <= fetch_addr;
                  rd_req   <= 1'b1;
                  is_fetch <= 1'b1;
                  state    <= cornet_pkg::BS_BYTE;
               end
               else if (sel_req.valid)
               begin
                  addr     <= sel_req.addr;
                  is_fetch <= 1'b0;
                  case (sel_req.kind)
                     cornet_pkg::BUS_READ_WORD:
                     begin
                        rd_req <= 1'b1;
                        state  <= cornet_pkg::BS_WORD_L;
                     end
                     cornet_pkg::BUS_WRITE:
                     begin
                        wr_en   <= 1'b1;
                        wr_data <= sel_req.wr_data;
                        state   <= cornet_pkg::BS_WRITE;
                     end
                     default:
                     begin
                        rd_req <= 1'b1;
                        state  <= cornet_pkg::BS_BYTE;
                     end
                  endcase
               end
            cornet_pkg::BS_BYTE:
               if (ready)
               begin
                  rd_byte    <= rd_data;
                  inst_valid <= is_fetch;
                  bus_done   <= !is_fetch;
                  state      <= cornet_pkg::BS_IDLE;
               end
            cornet_pkg::BS_WORD_L:
               if (ready)
               begin
                  rd_word[7:0] <= rd_data; // Little endian.
                  addr         <= addr + 1'b1;
                  rd_req       <= 1'b1;
                  state        <= cornet_pkg::BS_WORD_H;
               end
            cornet_pkg::BS_WORD_H:
               if (ready)
               begin
                  rd_word[15:8] <= rd_data;
                  bus_done      <= 1'b1;
                  state         <= cornet_pkg::BS_IDLE;
               end
            cornet_pkg::BS_WRITE:
            begin
               bus_done <= 1'b1; // Memory takes writes at once.
               state    <= cornet_pkg::BS_IDLE;
            end
            default:
               state <= cornet_pkg::BS_IDLE;
         endcase
      end
   end

   a_one_source: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0({fetch_req, operand_req.valid, data_req.valid}));

   // A new request only arrives once the previous access has finished.
   a_req_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
      (fetch_req || operand_req.valid || data_req.valid) |-> (state == cornet_pkg::BS_IDLE));

endmodule

`default_nettype wire

// ==== source/cornet_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module cornet_cpu (
   input  wire logic              clk,
   input  wire logic              reset_n,
   output cornet_pkg::addr_t      addr,
   input  wire cornet_pkg::byte_t rd_data,
   output cornet_pkg::byte_t      wr_data,
   output logic                   wr_en,
   output logic                   rd_req,
   input  wire logic              ready
);

   logic                 fetch_req;
   cornet_pkg::addr_t    fetch_addr;
   logic                 inst_valid;
   cornet_pkg::byte_t    rd_byte;
   cornet_pkg::addr_t    rd_word;
   logic                 start;
   logic                 boot;
   cornet_pkg::byte_t    opcode;
   cornet_pkg::addr_t    pc;
   logic                 inst_done;
   cornet_pkg::addr_t    pc_next;
   cornet_pkg::decoded_t decoded;
   cornet_pkg::bus_req_t operand_req;
   cornet_pkg::bus_req_t data_req;
   logic                 bus_done;

   cornet_fetch u_fetch (
      .clk        (clk),
      .reset_n    (reset_n),
      .fetch_req  (fetch_req),
      .fetch_addr (fetch_addr),
      .inst_valid (inst_valid),
      .rd_byte    (rd_byte),
      .start      (start),
      .opcode     (opcode),
      .pc         (pc),
      .boot       (boot),
      .inst_done  (inst_done),
      .pc_next    (pc_next)
   );

   cornet_decode u_decode (
      .clk         (clk),
      .reset_n     (reset_n),
      .start       (start),
      .boot        (boot),
      .opcode      (opcode),
      .pc          (pc),
      .decoded     (decoded),
      .operand_req (operand_req)
   );

   cornet_execute u_execute (
      .clk       (clk),
      .reset_n   (reset_n),
      .decoded   (decoded),
      .pc        (pc),
      .bus_done  (bus_done),
      .rd_byte   (rd_byte),
      .rd_word   (rd_word),
      .data_req  (data_req),
      .inst_done (inst_done),
      .pc_next   (pc_next)
   );

   cornet_bus u_bus (
      .clk         (clk),
      .reset_n     (reset_n),
      .fetch_req   (fetch_req),
      .fetch_addr  (fetch_addr),
      .operand_req (operand_req),
      .data_req    (data_req),
      .inst_valid  (inst_valid),
      .bus_done    (bus_done),
      .rd_byte     (rd_byte),
      .rd_word     (rd_word),
      .addr        (addr),
      .rd_req      (rd_req),
      .wr_en       (wr_en),
      .wr_data     (wr_data),
      .rd_data     (rd_data),
      .ready       (ready)
   );

endmodule

`default_nettype wire

// ==== verification/cornet_cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cornet_consts.svh"

module cornet_cpu_tb;

   localparam int PROG_LEN       = 40;
   localparam int MAX_ACCESSES   = 6;
   localparam int ACCESS_CYCLES  = 6;
   localparam int TIMEOUT_CYCLES = PROG_LEN * MAX_ACCESSES * ACCESS_CYCLES + 560;
   localparam cornet_pkg::addr_t PROG_BASE = 16'h0400;

   typedef struct packed {
      logic              is_write;
      cornet_pkg::addr_t addr;
      cornet_pkg::byte_t data;
   } access_t;

   logic              clk;
   logic              reset_n;
   cornet_pkg::addr_t addr;
   cornet_pkg::byte_t rd_data;
   cornet_pkg::byte_t wr_data;
   logic              wr_en;
   logic              rd_req;
   logic              ready;

   cornet_pkg::byte_t dut_mem [0:65535];
   cornet_pkg::byte_t model_mem [0:65535];
   cornet_pkg::byte_t prog_op [0:PROG_LEN-1];
   cornet_pkg::addr_t prog_addr [0:PROG_LEN-1];
   access_t           exp_q [$];
   logic [31:0]       rng_state = 32'd1116;
   int                cycle_count = 0;
   logic              pending = 1'b0;
   int                wait_cnt = 0;
   cornet_pkg::addr_t pend_addr = '0;
   logic              booted = 1'b0;
   int                self_jumps = 0;
   logic              finished = 1'b0;
   cornet_pkg::byte_t m_a;
   cornet_pkg::byte_t m_x;
   cornet_pkg::byte_t m_y;
   logic              m_z;
   logic              m_c;
   cornet_pkg::addr_t m_pc;

   cornet_cpu dut (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return 32'(rng_state[30:16]);
   endfunction

   // Instruction length from the 6502 addressing mode.
   function automatic int op_length(input cornet_pkg::byte_t op);
      case (op)
         `CORNET_OP_LDA_IMM, `CORNET_OP_LDX_IMM, `CORNET_OP_LDY_IMM, `CORNET_OP_AND_IMM,
         `CORNET_OP_ORA_IMM, `CORNET_OP_ADC_IMM, `CORNET_OP_CMP_IMM, `CORNET_OP_BEQ,
         `CORNET_OP_BNE: return 2;
         `CORNET_OP_LDA_ABS, `CORNET_OP_LDA_ABS_X, `CORNET_OP_STA_ABS, `CORNET_OP_STA_ABS_X,
         `CORNET_OP_JMP_ABS: return 3;
         default: return 1;
      endcase
   endfunction

   function automatic cornet_pkg::byte_t random_opcode();
      case (lcg_next() % 21)
         0: return `CORNET_OP_LDA_IMM;
         1: return `CORNET_OP_LDX_IMM;
         2: return `CORNET_OP_LDY_IMM;
         3: return `CORNET_OP_LDA_ABS;
         4: return `CORNET_OP_LDA_ABS_X;
         5: return `CORNET_OP_STA_ABS;
         6: return `CORNET_OP_STA_ABS_X;
         7: return `CORNET_OP_INX;
         8: return `CORNET_OP_DEX;
         9: return `CORNET_OP_TAX;
         10: return `CORNET_OP_TXA;
         11: return `CORNET_OP_AND_IMM;
         12: return `CORNET_OP_ORA_IMM;
         13: return `CORNET_OP_ADC_IMM;
         14: return `CORNET_OP_CMP_IMM;
         15: return `CORNET_OP_CLC;
         16: return `CORNET_OP_SEC;
         17: return `CORNET_OP_JMP_ABS;
         18: return `CORNET_OP_BEQ;
         19: return `CORNET_OP_BNE;
         default: return 8'hEA; // Not supported, runs as a no-op.
      endcase
   endfunction

   function automatic cornet_pkg::byte_t fill_byte(input cornet_pkg::addr_t a);
      return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3C;
   endfunction

   task automatic put_word(input cornet_pkg::addr_t a, input cornet_pkg::addr_t w);
      dut_mem[a]         = w[7:0];
      dut_mem[a + 16'd1] = w[15:8];
   endtask

   task automatic build_program();
      cornet_pkg::addr_t a;
      cornet_pkg::addr_t target;
      cornet_pkg::byte_t imm;
      int                i;
      int                j;
      for (i = 0; i < 65536; i++)
         dut_mem[i] = fill_byte(16'(i));
      put_word(`CORNET_RESET_VECTOR, PROG_BASE);
      a = PROG_BASE;
      for (i = 0; i < PROG_LEN; i++)
      begin
         prog_op[i]   = (i == PROG_LEN - 1) ? `CORNET_OP_JMP_ABS : random_opcode();
         prog_addr[i] = a;
         a            = a + cornet_pkg::addr_t'(op_length(prog_op[i]));
      end
      for (i = 0; i < PROG_LEN; i++)
      begin
         a          = prog_addr[i];
         dut_mem[a] = prog_op[i];
         j          = i + 1 + int'(lcg_next() % 3); // Forward only.
         if (j > PROG_LEN - 1)
            j = PROG_LEN - 1;
         target = (i == PROG_LEN - 1) ? a : prog_addr[j];
         imm    = (lcg_next() % 4 == 0) ? 8'h00 : 8'(lcg_next());
         case (prog_op[i])
            `CORNET_OP_BEQ, `CORNET_OP_BNE: dut_mem[a + 16'd1] = 8'(target - a - 16'd2);
            `CORNET_OP_JMP_ABS: put_word(a + 16'd1, target);
            `CORNET_OP_LDA_ABS: put_word(a + 16'd1, 16'h0200 + 16'(lcg_next() % 512));
            `CORNET_OP_LDA_ABS_X, `CORNET_OP_STA_ABS: put_word(a + 16'd1, 16'h0200 + 16'(imm));
            `CORNET_OP_STA_ABS_X: put_word(a + 16'd1, 16'h0200); // X keeps it in page 2.
            default:
               if (op_length(prog_op[i]) == 2)
                  dut_mem[a + 16'd1] = imm;
         endcase
      end
   endtask

   task automatic expect_read(input cornet_pkg::addr_t a);
      exp_q.push_back('{1'b0, a, 8'h00});
   endtask

   task automatic expect_write(input cornet_pkg::addr_t a, input cornet_pkg::byte_t d);
      exp_q.push_back('{1'b1, a, d});
   endtask

   // Runs one instruction and queues the accesses it makes.
   task automatic model_step();
      cornet_pkg::byte_t op;
      cornet_pkg::byte_t opnd;
      cornet_pkg::addr_t word;
      cornet_pkg::addr_t ea;
      cornet_pkg::addr_t next_pc;
      logic [8:0]        sum;
      if (!booted)
      begin
         expect_read(`CORNET_RESET_VECTOR);
         expect_read(`CORNET_RESET_VECTOR + 16'd1);
         m_pc   = {model_mem[`CORNET_RESET_VECTOR + 16'd1], model_mem[`CORNET_RESET_VECTOR]};
         m_a    = '0;
         m_x    = '0;
         m_y    = '0;
         m_z    = 1'b0;
         m_c    = 1'b0;
         booted = 1'b1;
      end
      else
      begin
         op   = model_mem[m_pc];
         opnd = model_mem[m_pc + 16'd1];
         word = {model_mem[m_pc + 16'd2], opnd};
         expect_read(m_pc);
         if (op_length(op) >= 2)
            expect_read(m_pc + 16'd1);
         if (op_length(op) == 3)
            expect_read(m_pc + 16'd2);
         next_pc = m_pc + cornet_pkg::addr_t'(op_length(op));
         ea      = word + 16'(m_x);
         case (op)
            `CORNET_OP_LDA_IMM: m_a = opnd;
            `CORNET_OP_LDX_IMM: m_x = opnd;
            `CORNET_OP_LDY_IMM: m_y = opnd;
            `CORNET_OP_LDA_ABS:
            begin
               expect_read(word);
               m_a = model_mem[word];
            end
            `CORNET_OP_LDA_ABS_X:
            begin
               expect_read(ea);
               m_a = model_mem[ea];
            end
            `CORNET_OP_STA_ABS:
            begin
               expect_write(word, m_a);
               model_mem[word] = m_a;
            end
            `CORNET_OP_STA_ABS_X:
            begin
               expect_write(ea, m_a);
               model_mem[ea] = m_a;
            end
            `CORNET_OP_INX: m_x = m_x + 8'd1;
            `CORNET_OP_DEX: m_x = m_x - 8'd1;
            `CORNET_OP_TAX: m_x = m_a;
            `CORNET_OP_TXA: m_a = m_x;
            `CORNET_OP_AND_IMM: m_a = m_a & opnd;
            `CORNET_OP_ORA_IMM: m_a = m_a | opnd;
            `CORNET_OP_ADC_IMM:
            begin
               sum        = {1'b0, m_a} + {1'b0, opnd} + 9'(m_c);
               {m_c, m_a} = sum;
            end
            `CORNET_OP_CLC: m_c = 1'b0;
            `CORNET_OP_SEC: m_c = 1'b1;
            default: ;
         endcase
         case (op)
            `CORNET_OP_LDA_IMM, `CORNET_OP_LDA_ABS, `CORNET_OP_LDA_ABS_X, `CORNET_OP_TXA,
            `CORNET_OP_AND_IMM, `CORNET_OP_ORA_IMM, `CORNET_OP_ADC_IMM: m_z = (m_a == 8'h00);
            `CORNET_OP_LDX_IMM, `CORNET_OP_INX, `CORNET_OP_DEX, `CORNET_OP_TAX:
               m_z = (m_x == 8'h00);
            `CORNET_OP_LDY_IMM: m_z = (m_y == 8'h00);
            `CORNET_OP_CMP_IMM:
            begin
               m_z = (m_a == opnd);
               m_c = (m_a >= opnd);
            end
            `CORNET_OP_JMP_ABS:
            begin
               if (word == m_pc)
                  self_jumps = self_jumps + 1;
               next_pc = word;
            end
            `CORNET_OP_BEQ, `CORNET_OP_BNE:
               if (m_z == (op == `CORNET_OP_BEQ))
                  next_pc = m_pc + 16'd2 + {{8{opnd[7]}}, opnd};
            default: ;
         endcase
         m_pc = next_pc;
         if (self_jumps == 2)
            finished = 1'b1; // Final loop fetched twice.
      end
   endtask

   task automatic halt_failed();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      $display("error at %0t: %s", $time, msg);
      halt_failed();
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      halt_failed();
   endtask

   task automatic check_access(input logic is_write, input cornet_pkg::addr_t a,
                               input cornet_pkg::byte_t d);
      access_t exp;
      if (exp_q.size() == 0)
         model_step();
      exp = exp_q.pop_front();
      assert (exp.is_write == is_write && exp.addr == a)
      else report_mismatch($sformatf("%s at %h, expected %s at %h",
                                     is_write ? "write" : "read",
                                     a, exp.is_write ? "write" : "read", exp.addr));
      if (is_write)
         assert (d == exp.data)
         else report_mismatch($sformatf("write data %h at %h, expected %h", d, a, exp.data));
   endtask

   initial
   begin
      clk = 1'b0;
      reset_n <= 1'b0;
      rd_data <= '0;
      ready   <= 1'b0;
      build_program();
      model_mem = dut_mem;
      repeat (3) @(posedge clk);
      reset_n <= 1'b1;
   end

   // Memory with random read latency, and the bus checks.
   always @(posedge clk)
   begin
      ready <= 1'b0;
      if (reset_n)
      begin
         assert (!(rd_req && wr_en))
         else abort_run("rd_req and wr_en were high in the same cycle");
         if (wr_en)
         begin
            check_access(1'b1, addr, wr_data);
            dut_mem[addr] = wr_data;
         end
         if (rd_req)
         begin
            assert (!pending)
            else abort_run("a new rd_req came before ready answered the previous one");
            check_access(1'b0, addr, 8'h00);
            pending   = 1'b1;
            pend_addr = addr;
            wait_cnt  = 1 + int'(lcg_next() % 4);
         end
         else if (pending)
            assert (addr == pend_addr)
            else report_mismatch($sformatf("addr moved to %h before the reply", addr));
         if (pending)
         begin
            if (wait_cnt == 1)
            begin
               ready   <= 1'b1;
               rd_data <= dut_mem[pend_addr];
               pending = 1'b0;
            end
            else
               wait_cnt = wait_cnt - 1;
         end
      end
      cycle_count = cycle_count + 1;
      if (finished)
      begin
         $display("All tests passed!");
         $finish;
      end
      else if (cycle_count >= TIMEOUT_CYCLES)
         abort_run("Timeout, the program did not reach its final loop");
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/cornet_pkg.sv
source/cornet_fetch.sv
source/cornet_decode.sv
source/cornet_execute.sv
source/cornet_bus.sv
source/cornet_cpu.sv
verification/cornet_cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the simulation fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f files.f \
   --top-module cornet_cpu_tb \
   -o cornet_sim

./obj_dir/cornet_sim
